/* run.sh */
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f verilog.f \
  || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/Vcache_tb 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qF "*** TEST PASSED ***" && exit 0 || exit 1

/* src/cache_ctrl.sv */
// direct-mapped write-back cache controller
// tag/valid/dirty store, miss handling, refill, write-back and flush

`timescale 1ns/1ps

`include "cache_params.svh"

module cache_ctrl import cache_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  cache_req_if.cache               bus,
  output logic                     o_mem_valid,
  output mem_op_e                  o_mem_op,
  output logic [`CACHE_ADDR_W-1:0] o_mem_addr,
  output logic [`CACHE_LINE_W-1:0] o_mem_wdata,
  input  logic                     i_mem_ready,
  input  logic [`CACHE_LINE_W-1:0] i_mem_rdata
);

  localparam int OFF_W = `CACHE_OFF_W;
  localparam int IDX_W = `CACHE_IDX_W;
  localparam int TAG_W = `CACHE_ADDR_W - IDX_W - OFF_W;

  ctrl_state_e              state;
  logic                     mem_valid;
  logic [TAG_W-1:0]         tag_q [`CACHE_LINES];
  logic [`CACHE_LINES-1:0]  valid_q;
  logic [`CACHE_LINES-1:0]  dirty_q;
  logic [IDX_W-1:0]         scan_idx;
  logic [TAG_W-1:0]         req_tag;
  logic [IDX_W-1:0]         req_idx;
  logic [IDX_W-1:0]         line_idx;
  logic                     hit;
  logic                     mem_done;
  logic                     fill_en;
  logic                     wr_en;
  logic [`CACHE_LINE_W-1:0] line_data;

  assign req_tag  = bus.addr[`CACHE_ADDR_W-1 -: TAG_W];
  assign req_idx  = bus.addr[OFF_W +: IDX_W];
  assign line_idx = (state == FLUSH_SCAN || state == FLUSH_WB) ? scan_idx : req_idx;
  assign hit      = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
  assign mem_done = mem_valid && i_mem_ready;
  assign fill_en  = (state == REFILL) && mem_done;
  assign wr_en    = (state == RESPOND) && (bus.op == OP_WRITE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      mem_valid <= 1'b0;
      valid_q   <= '0;
      dirty_q   <= '0;
      scan_idx  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (bus.req) begin
            if (bus.op == OP_FLUSH) begin
              scan_idx <= '0;
              state    <= FLUSH_SCAN;
            end else begin
              state <= LOOKUP;
            end
          end
        end
        LOOKUP: begin
          if (hit) state <= RESPOND;
          else if (valid_q[req_idx] && dirty_q[req_idx]) state <= WBACK;  // dirty victim
          else state <= REFILL;
        end
        WBACK: begin
          if (!mem_valid) begin
            mem_valid <= 1'b1;
          end else if (i_mem_ready) begin
            mem_valid <= 1'b0;  // one idle cycle before the refill
            state     <= REFILL;
          end
        end
        REFILL: begin
          if (!mem_valid) begin
            mem_valid <= 1'b1;
          end else if (i_mem_ready) begin
            mem_valid        <= 1'b0;
            valid_q[req_idx] <= 1'b1;
            dirty_q[req_idx] <= 1'b0;
            state            <= RESPOND;  // finish as a hit
          end
        end
        RESPOND: begin
          if (wr_en) dirty_q[req_idx] <= 1'b1;
          state <= IDLE;
        end
        FLUSH_SCAN: begin
          if (valid_q[scan_idx] && dirty_q[scan_idx]) state <= FLUSH_WB;
          else if (scan_idx == IDX_W'(`CACHE_LINES - 1)) state <= RESPOND;
          else scan_idx <= scan_idx + 1'b1;
        end
        FLUSH_WB: begin
          if (!mem_valid) begin
            mem_valid <= 1'b1;
          end else if (i_mem_ready) begin
            mem_valid         <= 1'b0;
            dirty_q[scan_idx] <= 1'b0;  // line stays valid
            state             <= FLUSH_SCAN;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // tags change only when a refill lands
  always_ff @(posedge clk) begin
    if (fill_en) tag_q[req_idx] <= req_tag;
  end

  cache_data_array u_data_array (
    .clk         (clk),
    .i_line_idx  (line_idx),
    .i_byte_off  (bus.addr[OFF_W-1:0]),
    .i_size      (bus.size),
    .i_wr_en     (wr_en),
    .i_wdata     (bus.wdata),
    .i_fill_en   (fill_en),
    .i_fill_data (i_mem_rdata),
    .o_line      (line_data),
    .o_rdata     (bus.rdata)
  );

  assign bus.ack = (state == RESPOND);

  // fields are stable while valid since tags and lines only change on completion
  assign o_mem_valid = mem_valid;
  assign o_mem_op    = (state == REFILL) ? MEM_READ : MEM_WRITE;
  assign o_mem_addr  = (state == REFILL) ? {req_tag, req_idx, {OFF_W{1'b0}}}
                                         : {tag_q[line_idx], line_idx, {OFF_W{1'b0}}};
  assign o_mem_wdata = line_data;

endmodule

/* src/cache_data_array.sv */
// cache line storage
// byte-lane writes, whole-line fill and right-aligned read extraction

`timescale 1ns/1ps

`include "cache_params.svh"

module cache_data_array import cache_pkg::*; (
  input  logic                     clk,
  input  logic [`CACHE_IDX_W-1:0]  i_line_idx,
  input  logic [`CACHE_OFF_W-1:0]  i_byte_off,
  input  access_size_e             i_size,
  input  logic                     i_wr_en,
  input  logic [63:0]              i_wdata,
  input  logic                     i_fill_en,
  input  logic [`CACHE_LINE_W-1:0] i_fill_data,
  output logic [`CACHE_LINE_W-1:0] o_line,
  output logic [63:0]              o_rdata
);

  localparam int LINE_BYTES = `CACHE_LINE_BYTES;
  localparam int LINE_W     = `CACHE_LINE_W;

  logic [LINE_W-1:0]     lines_q [`CACHE_LINES];
  logic [7:0]            size_lanes;   // lanes used within a doubleword
  logic [LINE_BYTES-1:0] lane_en;
  logic [LINE_W-1:0]     wr_line;
  logic [LINE_W-1:0]     rd_shift;
  logic [63:0]           rd_mask;

  always_comb begin
    case (i_size)
      SIZE_B:  size_lanes = 8'h01;
      SIZE_H:  size_lanes = 8'h03;
      SIZE_W:  size_lanes = 8'h0f;
      default: size_lanes = 8'hff;
    endcase
  end

  // move the write data and its lanes up to the byte offset
  assign lane_en = LINE_BYTES'(size_lanes) << i_byte_off;
  assign wr_line = LINE_W'(i_wdata) << {i_byte_off, 3'b000};

  always_ff @(posedge clk) begin
    if (i_fill_en) begin
      lines_q[i_line_idx] <= i_fill_data;  // refill wins over a store
    end else if (i_wr_en) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (lane_en[b]) lines_q[i_line_idx][b*8 +: 8] <= wr_line[b*8 +: 8];
      end
    end
  end

  assign o_line   = lines_q[i_line_idx];
  assign rd_shift = o_line >> {i_byte_off, 3'b000};

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      rd_mask[i*8 +: 8] = {8{size_lanes[i]}};
    end
  end

  assign o_rdata = rd_shift[63:0] & rd_mask;  // upper bytes zero

endmodule

/* src/cache_params.svh */
// cache geometry and traffic generator timing macros
// shared by the RTL and the testbench

`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cache geometry
`define CACHE_ADDR_W      64
`define CACHE_LINE_BYTES  64
`define CACHE_LINE_W      (`CACHE_LINE_BYTES * 8)
`define CACHE_LINES       8
`define CACHE_OFF_W       $clog2(`CACHE_LINE_BYTES)
`define CACHE_IDX_W       $clog2(`CACHE_LINES)

// generator timing and address pattern
`define GEN_GAP_CYCLES    10
`define GEN_STRIDE        64'h48       // moves line and offset each pair
`define GEN_BASE          64'h8000_0000
`define GEN_REGION_BYTES  64'd2048     // four times the cache size

`endif

/* src/cache_pkg.sv */
// shared enums for the cache subsystem
// access sizes, core opcodes, memory ops and controller states

package cache_pkg;

  // bytes per access 1/2/4/8
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } access_size_e;

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_FLUSH = 2'd2
  } cache_op_e;

  // line transfer direction on the memory port
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    LOOKUP     = 3'd1,
    WBACK      = 3'd2,  // victim line out
    REFILL     = 3'd3,  // new line in
    RESPOND    = 3'd4,
    FLUSH_SCAN = 3'd5,
    FLUSH_WB   = 3'd6
  } ctrl_state_e;

endpackage

/* src/cache_req_if.sv */
// core-side request/response bundle between generator and cache

`timescale 1ns/1ps

`include "cache_params.svh"

interface cache_req_if import cache_pkg::*; ();

  logic [`CACHE_ADDR_W-1:0] addr;
  logic [63:0]              wdata;
  access_size_e             size;
  cache_op_e                op;
  logic                     req;   // held until ack
  logic [63:0]              rdata; // right-aligned and valid with ack
  logic                     ack;   // single-cycle pulse

  modport requester (
    output addr, wdata, size, op, req,
    input  rdata, ack
  );

  modport cache (
    input  addr, wdata, size, op, req,
    output rdata, ack
  );

endinterface

/* src/cache_subsys_top.sv */
// cache subsystem top level
// traffic generator and cache controller joined by the request bus

`timescale 1ns/1ps

`include "cache_params.svh"

module cache_subsys_top import cache_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_start,
  input  logic [63:0]              i_key,
  input  logic [15:0]              i_pairs,
  output logic                     o_busy,
  output logic                     o_done,
  output logic                     o_err,
  output logic [`CACHE_ADDR_W-1:0] o_err_addr,
  output logic [15:0]              o_checks,
  // line-wide memory port
  output logic                     o_mem_valid,
  output mem_op_e                  o_mem_op,
  output logic [`CACHE_ADDR_W-1:0] o_mem_addr,
  output logic [`CACHE_LINE_W-1:0] o_mem_wdata,
  input  logic                     i_mem_ready,
  input  logic [`CACHE_LINE_W-1:0] i_mem_rdata
);

  cache_req_if req_bus ();

  cache_traffic_gen u_gen (
    .clk        (clk),
    .rst        (rst),
    .i_start    (i_start),
    .i_key      (i_key),
    .i_pairs    (i_pairs),
    .o_busy     (o_busy),
    .o_done     (o_done),
    .o_err      (o_err),
    .o_err_addr (o_err_addr),
    .o_checks   (o_checks),
    .bus        (req_bus.requester)
  );

  cache_ctrl u_cache (
    .clk         (clk),
    .rst         (rst),
    .bus         (req_bus.cache),
    .o_mem_valid (o_mem_valid),
    .o_mem_op    (o_mem_op),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .i_mem_ready (i_mem_ready),
    .i_mem_rdata (i_mem_rdata)
  );

endmodule

/* src/cache_traffic_gen.sv */
// write/read-back request generator with result checking
// ends each run with a flush of all dirty lines

`timescale 1ns/1ps

`include "cache_params.svh"

module cache_traffic_gen import cache_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_start,
  input  logic [63:0]              i_key,
  input  logic [15:0]              i_pairs,
  output logic                     o_busy,
  output logic                     o_done,
  output logic                     o_err,
  output logic [`CACHE_ADDR_W-1:0] o_err_addr,
  output logic [15:0]              o_checks,
  cache_req_if.requester           bus
);

  localparam int GAP_W = $clog2(`GEN_GAP_CYCLES + 1);

  typedef enum logic [1:0] {
    G_IDLE,
    G_GAP,   // idle cycles before the next request
    G_REQ    // request out, waiting for ack
  } gen_state_e;

  gen_state_e               gstate;
  cache_op_e                op_q;
  logic                     req_q;
  logic [GAP_W-1:0]         gap_cnt;
  logic [15:0]              pair_cnt;
  logic [15:0]              next_pair;
  logic [15:0]              total_q;
  logic [63:0]              key_q;
  logic [`CACHE_ADDR_W-1:0] addr_q;
  logic [`CACHE_ADDR_W-1:0] step_addr;
  logic [`CACHE_ADDR_W-1:0] next_addr;
  access_size_e             size;
  logic [63:0]              size_mask;
  logic [63:0]              exp_data;

  assign size = access_size_e'(pair_cnt[1:0]);  // B,H,W,D rotation

  always_comb begin
    case (size)
      SIZE_B:  size_mask = 64'h0000_0000_0000_00ff;
      SIZE_H:  size_mask = 64'h0000_0000_0000_ffff;
      SIZE_W:  size_mask = 64'h0000_0000_ffff_ffff;
      default: size_mask = 64'hffff_ffff_ffff_ffff;
    endcase
  end

  assign exp_data  = (key_q ^ addr_q) & size_mask;
  assign next_pair = pair_cnt + 16'd1;

  // wrap back to the base once past the region end
  assign step_addr = addr_q + `GEN_STRIDE;
  assign next_addr = (step_addr >= `GEN_BASE + `GEN_REGION_BYTES) ? `GEN_BASE : step_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      gstate   <= G_IDLE;
      req_q    <= 1'b0;
      op_q     <= OP_WRITE;
      pair_cnt <= '0;
      o_checks <= '0;
      o_err    <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      case (gstate)
        G_IDLE: begin
          if (i_start) begin
            key_q      <= i_key;
            total_q    <= i_pairs;
            addr_q     <= `GEN_BASE;
            pair_cnt   <= '0;
            gap_cnt    <= '0;
            o_checks   <= '0;
            o_err      <= 1'b0;
            o_err_addr <= '0;
            o_done     <= 1'b0;
            op_q       <= (i_pairs == 16'd0) ? OP_FLUSH : OP_WRITE;
            gstate     <= G_GAP;
          end
        end
        G_GAP: begin
          if (gap_cnt == GAP_W'(`GEN_GAP_CYCLES - 1)) begin
            req_q  <= 1'b1;
            gstate <= G_REQ;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        G_REQ: begin
          if (bus.ack) begin
            req_q   <= 1'b0;
            gap_cnt <= '0;
            gstate  <= G_GAP;
            case (op_q)
              OP_WRITE: op_q <= OP_READ;  // read the same address back
              OP_READ: begin
                o_checks <= o_checks + 16'd1;
                if (bus.rdata != exp_data && !o_err) begin  // keep the first one only
                  o_err      <= 1'b1;
                  o_err_addr <= addr_q;
                end
                pair_cnt <= next_pair;
                addr_q   <= next_addr;
                op_q     <= (next_pair == total_q) ? OP_FLUSH : OP_WRITE;
              end
              default: begin
                // flush acked so the run is over
                o_done <= 1'b1;
                gstate <= G_IDLE;
              end
            endcase
          end
        end
        default: gstate <= G_IDLE;
      endcase
    end
  end

  assign o_busy    = (gstate != G_IDLE);
  assign bus.req   = req_q;
  assign bus.op    = op_q;
  assign bus.addr  = addr_q;
  assign bus.size  = size;
  assign bus.wdata = exp_data;

endmodule

/* test/cache_assertions.sv */
// concurrent checks on the core request and memory handshakes
// bound into the cache controller

`timescale 1ns/1ps

`include "cache_params.svh"

module cache_assertions import cache_pkg::*; (
  input logic                     clk,
  input logic                     rst,
  input logic                     ack,
  input ctrl_state_e              state,
  input logic                     mem_valid,
  input mem_op_e                  mem_op,
  input logic [`CACHE_ADDR_W-1:0] mem_addr,
  input logic [`CACHE_LINE_W-1:0] mem_wdata,
  input logic                     mem_ready
);

  // ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else $error("core ack stayed high for two cycles in a row");

  // request held with all fields until ready
  mem_req_stable: assert property (@(posedge clk) disable iff (rst)
      mem_valid && !mem_ready |=>
        mem_valid && $stable(mem_op) && $stable(mem_addr) && $stable(mem_wdata))
    else $error("memory request dropped or changed before ready");

  no_mem_in_idle: assert property (@(posedge clk) disable iff (rst)
      state == IDLE |-> !mem_valid)
    else $error("memory valid raised while the controller is idle");

endmodule

bind cache_ctrl cache_assertions u_assertions (
  .clk       (clk),
  .rst       (rst),
  .ack       (bus.ack),
  .state     (state),
  .mem_valid (o_mem_valid),
  .mem_op    (o_mem_op),
  .mem_addr  (o_mem_addr),
  .mem_wdata (o_mem_wdata),
  .mem_ready (i_mem_ready)
);

/* test/cache_tb.sv */
// testbench for the cache subsystem
// memory model with random ready delay, reference cache model and checks

`timescale 1ns/1ps

`include "cache_params.svh"

module cache_tb import cache_pkg::*; ();

  localparam int LINE_W     = `CACHE_LINE_W;
  localparam int LINE_BYTES = `CACHE_LINE_BYTES;
  localparam int REGION     = `GEN_REGION_BYTES;
  localparam int NUM_RUNS   = 3;

  logic               clk         = 1'b0;
  logic               rst         = 1'b1;
  logic               i_start     = 1'b0;
  logic [63:0]        i_key       = '0;
  logic [15:0]        i_pairs     = '0;
  logic               i_mem_ready = 1'b0;
  logic [LINE_W-1:0]  i_mem_rdata = '0;
  logic               o_busy;
  logic               o_done;
  logic               o_err;
  logic [63:0]        o_err_addr;
  logic [15:0]        o_checks;
  logic               o_mem_valid;
  mem_op_e            o_mem_op;
  logic [63:0]        o_mem_addr;
  logic [LINE_W-1:0]  o_mem_wdata;

  logic [7:0]         mem [REGION];       // memory model
  logic [7:0]         exp_mem [REGION];   // expected image
  logic [63:0]        ref_line [`CACHE_LINES];  // line address held per index
  bit                 ref_valid [`CACHE_LINES];
  bit                 ref_dirty [`CACHE_LINES];
  mem_op_e            pred_op_q [$];      // predicted memory transfers in order
  logic [63:0]        pred_addr_q [$];
  logic [LINE_W-1:0]  pred_data_q [$];
  logic               ready_pending = 1'b0;
  int                 ready_wait = 0;
  int                 limit_cycles = 0;

  always #10 clk = ~clk;

  cache_subsys_top dut_i (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .i_key       (i_key),
    .i_pairs     (i_pairs),
    .o_busy      (o_busy),
    .o_done      (o_done),
    .o_err       (o_err),
    .o_err_addr  (o_err_addr),
    .o_checks    (o_checks),
    .o_mem_valid (o_mem_valid),
    .o_mem_op    (o_mem_op),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .i_mem_ready (i_mem_ready),
    .i_mem_rdata (i_mem_rdata)
  );

  task automatic stop_with_message(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [LINE_W-1:0] got,
                             input logic [LINE_W-1:0] exp);
    stop_with_message($sformatf("Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
  endtask

  // power-up byte is the low address byte xor a5
  function automatic logic [7:0] init_byte(input int i);
    logic [63:0] a;
    a = `GEN_BASE + i;
    return a[7:0] ^ 8'ha5;
  endfunction

  function automatic logic [LINE_W-1:0] line_from_image(input logic [63:0] line_addr,
                                                        input bit use_expected);
    logic [LINE_W-1:0] line;
    int                base;
    base = int'(line_addr - `GEN_BASE);
    for (int i = 0; i < LINE_BYTES; i++) begin
      line[i*8 +: 8] = use_expected ? exp_mem[base + i] : mem[base + i];
    end
    return line;
  endfunction

  task automatic push_transfer(input mem_op_e op, input logic [63:0] line_addr);
    pred_op_q.push_back(op);
    pred_addr_q.push_back(line_addr);
    pred_data_q.push_back(op == MEM_WRITE ? line_from_image(line_addr, 1'b1) : '0);
  endtask

  // direct-mapped lookup; a miss evicts a dirty victim and refills
  task automatic model_access(input logic [63:0] addr, input bit is_write);
    logic [63:0] line_addr;
    int          idx;
    line_addr = addr - (addr % LINE_BYTES);
    idx       = int'((addr / LINE_BYTES) % `CACHE_LINES);
    if (!(ref_valid[idx] && ref_line[idx] == line_addr)) begin
      if (ref_valid[idx] && ref_dirty[idx]) push_transfer(MEM_WRITE, ref_line[idx]);
      push_transfer(MEM_READ, line_addr);
      ref_valid[idx] = 1'b1;
      ref_line[idx]  = line_addr;
      ref_dirty[idx] = 1'b0;
    end
    if (is_write) ref_dirty[idx] = 1'b1;
  endtask

  task automatic build_run_model(input logic [63:0] key, input int pairs);
    logic [63:0] addr;
    logic [63:0] value;
    int          nbytes;
    addr = `GEN_BASE;
    for (int n = 0; n < pairs; n++) begin
      nbytes = 1 << (n % 4);  // byte, half, word, double
      value  = key ^ addr;
      model_access(addr, 1'b1);
      for (int b = 0; b < nbytes; b++) begin
        exp_mem[int'(addr - `GEN_BASE) + b] = value[b*8 +: 8];
      end
      model_access(addr, 1'b0);
      addr = addr + `GEN_STRIDE;
      if (addr >= `GEN_BASE + `GEN_REGION_BYTES) addr = `GEN_BASE;
    end
    // flush goes through the indices in order
    for (int i = 0; i < `CACHE_LINES; i++) begin
      if (ref_valid[i] && ref_dirty[i]) begin
        push_transfer(MEM_WRITE, ref_line[i]);
        ref_dirty[i] = 1'b0;
      end
    end
  endtask

  task automatic check_request();
    assert (o_mem_addr % LINE_BYTES == 0)
      else value_error("o_mem_addr[5:0]", o_mem_addr % LINE_BYTES, 0);
    assert (o_mem_addr >= `GEN_BASE && o_mem_addr < `GEN_BASE + `GEN_REGION_BYTES)
      else stop_with_message($sformatf("memory request at 0x%0h lies outside the test region",
                                       o_mem_addr));
  endtask

  task automatic complete_transfer();
    mem_op_e           exp_op;
    logic [63:0]       exp_addr;
    logic [LINE_W-1:0] exp_data;
    int                base;
    assert (pred_op_q.size() != 0)
      else stop_with_message("memory transfer seen after all predicted transfers were done");
    exp_op   = pred_op_q.pop_front();
    exp_addr = pred_addr_q.pop_front();
    exp_data = pred_data_q.pop_front();
    assert (o_mem_op == exp_op) else value_error("o_mem_op", o_mem_op, exp_op);
    assert (o_mem_addr == exp_addr) else value_error("o_mem_addr", o_mem_addr, exp_addr);
    if (o_mem_op == MEM_WRITE) begin
      assert (o_mem_wdata == exp_data) else value_error("o_mem_wdata", o_mem_wdata, exp_data);
      base = int'(o_mem_addr - `GEN_BASE);
      for (int i = 0; i < LINE_BYTES; i++) begin
        mem[base + i] = o_mem_wdata[i*8 +: 8];
      end
    end
  endtask

  // memory model raises ready after a random delay and completes on valid and ready
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REGION; i++) begin
        mem[i] = init_byte(i);
      end
      i_mem_ready   <= 1'b0;
      ready_pending <= 1'b0;
    end else if (i_mem_ready && o_mem_valid) begin
      complete_transfer();
      i_mem_ready <= 1'b0;
    end else if (o_mem_valid && !ready_pending) begin
      check_request();
      ready_pending <= 1'b1;
      ready_wait    <= $urandom % 4;
    end else if (o_mem_valid && ready_wait == 0) begin
      i_mem_ready   <= 1'b1;
      i_mem_rdata   <= line_from_image(o_mem_addr, 1'b0);
      ready_pending <= 1'b0;
    end else if (o_mem_valid) begin
      ready_wait <= ready_wait - 1;
    end
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    stop_with_message("timeout: the runs did not finish within the cycle limit");
  end

  initial begin : main
    logic [63:0] keys [NUM_RUNS];
    int          pairs [NUM_RUNS];
    int          total;
    void'($urandom(32'h1115));
    total = 0;
    for (int r = 0; r < NUM_RUNS; r++) begin
      keys[r]  = {$urandom, $urandom};
      pairs[r] = 20 + ($urandom % 41);
      total    += pairs[r];
    end
    limit_cycles = total * 200 + 2000;
    for (int i = 0; i < REGION; i++) begin
      exp_mem[i] = init_byte(i);
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (o_busy == 1'b0) else value_error("o_busy", o_busy, 0);
    assert (o_done == 1'b0) else value_error("o_done", o_done, 0);
    assert (o_err == 1'b0) else value_error("o_err", o_err, 0);
    assert (o_mem_valid == 1'b0) else value_error("o_mem_valid", o_mem_valid, 0);
    for (int r = 0; r < NUM_RUNS; r++) begin
      build_run_model(keys[r], pairs[r]);
      i_key   <= keys[r];
      i_pairs <= 16'(pairs[r]);
      i_start <= 1'b1;
      @(posedge clk);
      i_start <= 1'b0;
      do @(posedge clk); while (o_done !== 1'b1);
      assert (o_err == 1'b0) else value_error("o_err", o_err, 0);
      assert (o_err_addr == '0) else value_error("o_err_addr", o_err_addr, 0);
      assert (o_checks == 16'(pairs[r])) else value_error("o_checks", o_checks, pairs[r]);
      assert (pred_op_q.size() == 0)
        else stop_with_message("run ended with predicted memory transfers still missing");
      for (int i = 0; i < REGION; i++) begin
        assert (mem[i] == exp_mem[i])
          else value_error($sformatf("mem[0x%0h]", `GEN_BASE + i), mem[i], exp_mem[i]);
      end
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+src
src/cache_pkg.sv
src/cache_req_if.sv
src/cache_traffic_gen.sv
src/cache_data_array.sv
src/cache_ctrl.sv
src/cache_subsys_top.sv
test/cache_assertions.sv
test/cache_tb.sv
